//--- include/ntt_cfg.svh
/*
 * constants of the NTT butterfly over q = 12289
 * Montgomery radix R = 2^16 and residue width
 */

`ifndef NTT_CFG_SVH
`define NTT_CFG_SVH

// prime modulus of the transform
`define NTT_Q           14'd12289

// -q^-1 mod 2^16, drives the Montgomery quotient
`define NTT_QINV_NEG    16'd12287

// log2 of the Montgomery radix
`define NTT_R_BITS      16

// bits per residue below q
`define NTT_COEFF_W     14

`endif

//--- verilog/ntt_pkg.sv
/*
 * vector types shared by the butterfly pipeline stages
 */

`default_nettype none

`include "ntt_cfg.svh"

package ntt_pkg;

    // one residue modulo q
    typedef logic [`NTT_COEFF_W-1:0] coeff_t;

    // full product of two residues
    typedef logic [2*`NTT_COEFF_W-1:0] prod_t;

    // Montgomery quotient, low R bits only
    typedef logic [`NTT_R_BITS-1:0] mont_t;

    // reduced value before the last correction, below 2q
    typedef logic [`NTT_COEFF_W:0] red_t;

endpackage

`default_nettype wire

//--- verilog/bfly_mult_stage.sv
/*
 * butterfly stage 1
 * v times twiddle into a 28-bit product, u carried alongside
 */

`timescale 1ns/10ps
`default_nettype none

module bfly_mult_stage (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             in_valid,
    output logic            in_ready,
    input  ntt_pkg::coeff_t in_u,
    input  ntt_pkg::coeff_t in_v,
    input  ntt_pkg::coeff_t in_w,
    output logic            mult_valid,
    input  wire             mult_ready,
    output ntt_pkg::coeff_t mult_u,
    output ntt_pkg::prod_t  mult_prod
);

    import ntt_pkg::*;

    prod_t prod;

    // ------------------------------------------------------------------
    // multiplier
    // ------------------------------------------------------------------
    assign prod = prod_t'(in_v) * prod_t'(in_w);

    // ------------------------------------------------------------------
    // output register and handshake
    // ------------------------------------------------------------------

    // take a new item when empty or when the next stage drains us
    assign in_ready = !mult_valid || mult_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mult_valid <= 1'b0;
        end else if (in_ready) begin
            mult_valid <= in_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            mult_u    <= in_u;
            mult_prod <= prod;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mont_reduce_stage.sv
/*
 * butterfly stage 2
 * Montgomery reduction of v*w, t = v*w*R^-1 mod q
 */

`timescale 1ns/10ps
`default_nettype none

`include "ntt_cfg.svh"

module mont_reduce_stage (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             mult_valid,
    output logic            mult_ready,
    input  ntt_pkg::coeff_t mult_u,
    input  ntt_pkg::prod_t  mult_prod,
    output logic            red_valid,
    input  wire             red_ready,
    output ntt_pkg::coeff_t red_u,
    output ntt_pkg::coeff_t red_t
);

    import ntt_pkg::*;

    mont_t                                 prod_lo;
    mont_t                                 quot;
    logic [`NTT_R_BITS+`NTT_COEFF_W:0]     prod_ext;
    logic [`NTT_R_BITS+`NTT_COEFF_W:0]     quot_ext;
    logic [`NTT_R_BITS+`NTT_COEFF_W:0]     q_ext;
    logic [`NTT_R_BITS+`NTT_COEFF_W:0]     acc;
    ntt_pkg::red_t                         red_raw;
    ntt_pkg::red_t                         red_fix;
    ntt_pkg::red_t                         q_red;
    coeff_t                                t_nxt;

    // ------------------------------------------------------------------
    // reduction datapath
    // ------------------------------------------------------------------

    // quotient m = x * (-q^-1) mod R
    assign prod_lo = mult_prod[`NTT_R_BITS-1:0];
    assign quot    = prod_lo * `NTT_QINV_NEG;

    // x + m*q is a multiple of R, below 2qR
    assign prod_ext = {{(`NTT_R_BITS-`NTT_COEFF_W+1){1'b0}}, mult_prod};
    assign quot_ext = {{(`NTT_COEFF_W+1){1'b0}}, quot};
    assign q_ext    = {{(`NTT_R_BITS+1){1'b0}}, `NTT_Q};
    assign acc      = prod_ext + quot_ext * q_ext;

    // divide by R, then one conditional subtract
    assign red_raw = acc[`NTT_R_BITS+`NTT_COEFF_W:`NTT_R_BITS];
    assign q_red   = {1'b0, `NTT_Q};
    assign red_fix = (red_raw >= q_red) ? (red_raw - q_red) : red_raw;
    assign t_nxt   = red_fix[`NTT_COEFF_W-1:0];

    // ------------------------------------------------------------------
    // output register and handshake
    // ------------------------------------------------------------------
    assign mult_ready = !red_valid || red_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red_valid <= 1'b0;
        end else if (mult_ready) begin
            red_valid <= mult_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mult_valid && mult_ready) begin
            red_u <= mult_u;
            red_t <= t_nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mod_addsub_stage.sv
/*
 * butterfly stage 3
 * sum and difference of u and t, both reduced mod q
 */

`timescale 1ns/10ps
`default_nettype none

`include "ntt_cfg.svh"

module mod_addsub_stage (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             red_valid,
    output logic            red_ready,
    input  ntt_pkg::coeff_t red_u,
    input  ntt_pkg::coeff_t red_t,
    output logic            out_valid,
    input  wire             out_ready,
    output ntt_pkg::coeff_t out_sum,
    output ntt_pkg::coeff_t out_diff
);

    import ntt_pkg::*;

    ntt_pkg::red_t sum_raw;
    ntt_pkg::red_t sum_red;
    ntt_pkg::red_t q_wide;
    coeff_t        sum_nxt;
    coeff_t        diff_nxt;

    // ------------------------------------------------------------------
    // modular add and subtract
    // ------------------------------------------------------------------
    assign q_wide = {1'b0, `NTT_Q};

    always_comb begin
        sum_raw = {1'b0, red_u} + {1'b0, red_t};
        if (sum_raw >= q_wide) begin
            sum_red = sum_raw - q_wide;
        end else begin
            sum_red = sum_raw;
        end
        sum_nxt = sum_red[`NTT_COEFF_W-1:0];

        // wraps back into range when t > u
        if (red_u >= red_t) begin
            diff_nxt = red_u - red_t;
        end else begin
            diff_nxt = red_u - red_t + `NTT_Q;
        end
    end

    // ------------------------------------------------------------------
    // output register, held while out_ready is low
    // ------------------------------------------------------------------
    assign red_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (red_ready) begin
            out_valid <= red_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (red_valid && red_ready) begin
            out_sum  <= sum_nxt;
            out_diff <= diff_nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ntt_bfly_pipe.sv
/*
 * NTT butterfly top, three-stage valid/ready pipeline
 * multiply, Montgomery reduce, modular add/subtract
 */

`timescale 1ns/10ps
`default_nettype none

module ntt_bfly_pipe (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             in_valid,
    output logic            in_ready,
    input  ntt_pkg::coeff_t in_u,
    input  ntt_pkg::coeff_t in_v,
    input  ntt_pkg::coeff_t in_w,
    output logic            out_valid,
    input  wire             out_ready,
    output ntt_pkg::coeff_t out_sum,
    output ntt_pkg::coeff_t out_diff
);

    import ntt_pkg::*;

    // stage 1 to stage 2
    logic   mult_valid;
    logic   mult_ready;
    coeff_t mult_u;
    prod_t  mult_prod;

    // stage 2 to stage 3
    logic   red_valid;
    logic   red_ready;
    coeff_t red_u;
    coeff_t red_t;

    // ------------------------------------------------------------------
    // stages, ready runs back through all three
    // ------------------------------------------------------------------
    bfly_mult_stage mult_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_u       (in_u),
        .in_v       (in_v),
        .in_w       (in_w),
        .mult_valid (mult_valid),
        .mult_ready (mult_ready),
        .mult_u     (mult_u),
        .mult_prod  (mult_prod)
    );

    mont_reduce_stage reduce_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mult_valid (mult_valid),
        .mult_ready (mult_ready),
        .mult_u     (mult_u),
        .mult_prod  (mult_prod),
        .red_valid  (red_valid),
        .red_ready  (red_ready),
        .red_u      (red_u),
        .red_t      (red_t)
    );

    mod_addsub_stage addsub_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .red_valid  (red_valid),
        .red_ready  (red_ready),
        .red_u      (red_u),
        .red_t      (red_t),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_sum    (out_sum),
        .out_diff   (out_diff)
    );

endmodule

`default_nettype wire

//--- bench/ntt_bfly_assertions.sv
/*
 * handshake and range assertions, bound into ntt_bfly_pipe
 */

`timescale 1ns/10ps
`default_nettype none

`include "ntt_cfg.svh"

module ntt_bfly_assertions (
    input wire             clk,
    input wire             rst_n,
    input wire             in_ready,
    input wire             out_valid,
    input wire             out_ready,
    input ntt_pkg::coeff_t out_sum,
    input ntt_pkg::coeff_t out_diff
);

    import ntt_pkg::*;

    localparam coeff_t Q_LIMIT = `NTT_Q;

    // a stalled result keeps valid and data
    hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_sum) && $stable(out_diff)))
        else $error("result changed while out_ready was low");

    range_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_sum < Q_LIMIT) && (out_diff < Q_LIMIT))
        else $error("result not below q");

    // ready passes straight back when nothing stalls
    ready_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_ready |-> in_ready)
        else $error("in_ready low while out_ready high");

endmodule

bind ntt_bfly_pipe ntt_bfly_assertions assertions_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_sum   (out_sum),
    .out_diff  (out_diff)
);

`default_nettype wire

//--- bench/ntt_bfly_tb.sv
/*
 * testbench for the NTT butterfly pipeline
 * stimulus table, reference model, scoreboard and timeout
 */

`timescale 1ns/10ps
`default_nettype none

`include "ntt_cfg.svh"

module ntt_bfly_tb;

    import ntt_pkg::*;

    localparam int Q         = int'(`NTT_Q);
    localparam int R_VAL     = 1 << `NTT_R_BITS;
    localparam int NUM_EDGE  = 10;
    localparam int NUM_TESTS = NUM_EDGE + 200;
    localparam int TIMEOUT   = 4 * NUM_TESTS + 100;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    logic   in_ready;
    coeff_t in_u;
    coeff_t in_v;
    coeff_t in_w;
    logic   out_valid;
    logic   out_ready;
    coeff_t out_sum;
    coeff_t out_diff;

    // stimulus table
    string  test_name [NUM_TESTS];
    coeff_t test_u    [NUM_TESTS];
    coeff_t test_v    [NUM_TESTS];
    coeff_t test_w    [NUM_TESTS];

    // scoreboard, one entry per accepted triple
    string  exp_name_q  [$];
    coeff_t exp_sum_q   [$];
    coeff_t exp_diff_q  [$];
    int     acc_cycle_q [$];

    string  drive_name;
    int     rinv;
    int     cycle;
    int     accepted;
    int     produced;
    int     last_out_cycle;
    bit     backpressure;

    ntt_bfly_pipe dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_u      (in_u),
        .in_v      (in_v),
        .in_w      (in_w),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_sum   (out_sum),
        .out_diff  (out_diff)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(10) clk = ~clk;
        end
    end

    // ------------------------------------------------------------------
    // reference model and compare tasks
    // ------------------------------------------------------------------
    function automatic int find_r_inverse();
        int x;
        int found;
        found = 0;
        for (x = 1; x < Q; x++) begin
            if (found == 0 && (x * R_VAL) % Q == 1) begin
                found = x;
            end
        end
        return found;
    endfunction

    // t = v * w * R^-1 mod q
    function automatic int twiddle_product(int v, int w);
        return (((v * w) % Q) * rinv) % Q;
    endfunction

    task automatic stop_on_failure(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_coeff(string name, coeff_t expected, coeff_t actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("ERROR: %s expected %0d actual %0d",
                                      name, expected, actual));
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        if (actual != expected) begin
            stop_on_failure($sformatf("ERROR: %s expected %0d actual %0d",
                                      name, expected, actual));
        end
    endtask

    task automatic set_entry(int idx, string name, int u, int v, int w);
        test_name[idx] = name;
        test_u[idx]    = coeff_t'(u);
        test_v[idx]    = coeff_t'(v);
        test_w[idx]    = coeff_t'(w);
    endtask

    task automatic fill_table();
        int i;
        int ru;
        int rv;
        int rw;
        set_entry(0, "zeros", 0, 0, 0);
        set_entry(1, "u_max", Q - 1, 0, 0);
        set_entry(2, "v_max_w_one", 0, Q - 1, 1);
        set_entry(3, "w_max_v_one", 0, 1, Q - 1);
        set_entry(4, "all_max", Q - 1, Q - 1, Q - 1);
        set_entry(5, "diff_wrap", 0, 1, 1);
        set_entry(6, "sum_wrap", Q - 1, 1, 1);
        set_entry(7, "w_zero", 1234, 4321, 0);
        set_entry(8, "v_zero", 4321, 0, 1234);
        // v = R mod q gives t = 1
        set_entry(9, "t_is_one", 0, R_VAL % Q, 1);
        for (i = NUM_EDGE; i < NUM_TESTS; i++) begin
            ru = int'($urandom_range(Q - 1, 0));
            rv = int'($urandom_range(Q - 1, 0));
            rw = int'($urandom_range(Q - 1, 0));
            set_entry(i, $sformatf("random_%0d", i - NUM_EDGE), ru, rv, rw);
        end
    endtask

    // ------------------------------------------------------------------
    // driver, monitor and out_ready pattern
    // ------------------------------------------------------------------
    task automatic send_entry(int idx);
        @(negedge clk);
        drive_name = backpressure ? {"bp_", test_name[idx]} : test_name[idx];
        in_valid   = 1'b1;
        in_u       = test_u[idx];
        in_v       = test_v[idx];
        in_w       = test_w[idx];
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
    endtask

    // stages are empty once out_valid stays low for three cycles
    task automatic wait_for_drain();
        int idle;
        idle = 0;
        while (idle < 3) begin
            @(negedge clk);
            if (out_valid) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
    endtask

    task automatic record_input();
        int t;
        t = twiddle_product(int'(in_v), int'(in_w));
        exp_name_q.push_back(drive_name);
        exp_sum_q.push_back(coeff_t'((int'(in_u) + t) % Q));
        exp_diff_q.push_back(coeff_t'((int'(in_u) + Q - t) % Q));
        acc_cycle_q.push_back(cycle);
        accepted++;
    endtask

    task automatic check_output();
        string name;
        int    acc_cycle;
        if (exp_sum_q.size() == 0) begin
            stop_on_failure("a result came out with no accepted input left for it");
        end else begin
            name      = exp_name_q.pop_front();
            acc_cycle = acc_cycle_q.pop_front();
            check_coeff({name, " sum"}, exp_sum_q.pop_front(), out_sum);
            check_coeff({name, " diff"}, exp_diff_q.pop_front(), out_diff);
            if (!backpressure) begin
                check_count({name, " latency"}, 3, cycle - acc_cycle);
                if (last_out_cycle >= 0) begin
                    check_count({name, " spacing"}, 1, cycle - last_out_cycle);
                end
            end
            last_out_cycle = cycle;
            produced++;
        end
    endtask

    // values seen here are those from before the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (in_valid && in_ready) begin
                record_input();
            end
            if (out_valid && out_ready) begin
                check_output();
            end
        end
        cycle = cycle + 1;
        if (cycle >= TIMEOUT) begin
            stop_on_failure($sformatf("timeout after %0d cycles, results are missing", cycle));
        end
    end

    always @(negedge clk) begin
        if (backpressure) begin
            out_ready = ($urandom_range(1, 0) != 0);
        end else begin
            out_ready = 1'b1;
        end
    end

    initial begin
        int idx;
        void'($urandom(48));
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_u           = '0;
        in_v           = '0;
        in_w           = '0;
        out_ready      = 1'b1;
        drive_name     = "";
        backpressure   = 1'b0;
        cycle          = 0;
        accepted       = 0;
        produced       = 0;
        last_out_cycle = -1;
        rinv           = find_r_inverse();
        fill_table();

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_count("reset out_valid", 0, int'(out_valid));
        check_count("reset in_ready", 1, int'(in_ready));

        // full rate pass, in_valid and out_ready held high
        for (idx = 0; idx < NUM_TESTS; idx++) begin
            send_entry(idx);
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait_for_drain();

        // same table again with out_ready low about half the time
        @(posedge clk);
        backpressure = 1'b1;
        for (idx = 0; idx < NUM_TESTS; idx++) begin
            send_entry(idx);
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait_for_drain();

        check_count("accepted inputs", 2 * NUM_TESTS, accepted);
        check_count("results", accepted, produced);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
verilog/ntt_pkg.sv
verilog/bfly_mult_stage.sv
verilog/mont_reduce_stage.sv
verilog/mod_addsub_stage.sv
verilog/ntt_bfly_pipe.sv
bench/ntt_bfly_assertions.sv
bench/ntt_bfly_tb.sv

//--- Makefile
# Verilator build and run of the NTT butterfly testbench

VERILATOR ?= verilator
TOP       ?= ntt_bfly_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv bench/*.sv include/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
